//--- common/a2_bus_pkg.sv
package a2_bus_pkg;

    // Bus clocks brought into the logic domain
    localparam int NUM_BUS_CLOCKS = 2;

    // Index of each bus clock in the filter loop
    localparam int BUS_CLK_PHI1 = 0;
    localparam int BUS_CLK_7M = 1;

    // Synchronizer depth ahead of the glitch filter
    localparam int SYNC_STAGES = 2;

    // Consecutive equal samples before the filtered level may change
    localparam int DENOISE_SAMPLES = 3;

    // Logic cycles without a Phi1 edge before the bus counts as asleep
    localparam int SLEEP_TIMEOUT_CYCLES = 64;
    localparam int IDLE_CNT_W = $clog2(SLEEP_TIMEOUT_CYCLES + 1);

    localparam int BUS_ADDR_W = 16;
    localparam int BUS_DATA_W = 8;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // Speaker soft switch, reads and writes both click
    localparam bus_addr_t SPEAKER_ADDR = 16'hC030;

endpackage

//--- common/a2_audio_pkg.sv
package a2_audio_pkg;

    // Slot cards feeding data, IRQ and audio
    localparam int NUM_CARDS = 3;

    // Raw card sample, unsigned
    localparam int CARD_AUDIO_W = 10;
    typedef logic [CARD_AUDIO_W-1:0] card_audio_t;

    // Card samples land in 13 bits, speaker sits on bit 12
    localparam int CARD_AUDIO_SHIFT = 3;
    localparam int SPEAKER_SHIFT = 12;
    localparam int MIX_PART_W = CARD_AUDIO_W + CARD_AUDIO_SHIFT;

    // Mixed output sample
    localparam int MIX_W = 16;
    typedef logic signed [MIX_W-1:0] mix_sample_t;

endpackage

//--- design/signal_denoise.sv
`timescale 1ns/1ps

module signal_denoise (
    input  logic clk_logic_w,
    input  logic arst_n_i,
    input  logic sig_i,
    output logic level_o,
    output logic rise_o,
    output logic fall_o
);

    import a2_bus_pkg::*;

    logic [SYNC_STAGES-1:0]     sync_r;
    logic [DENOISE_SAMPLES-2:0] hist_r;
    logic [DENOISE_SAMPLES-1:0] window_w;
    logic                       all_high_w;
    logic                       all_low_w;
    logic                       level_r;
    logic                       rise_r;
    logic                       fall_r;

    // Newest synchronized sample in bit 0, older ones above it
    assign window_w   = {hist_r, sync_r[SYNC_STAGES-1]};
    assign all_high_w = &window_w;
    assign all_low_w  = ~|window_w;

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_r <= '0;
            hist_r <= '0;
        end else begin
            sync_r <= {sync_r[SYNC_STAGES-2:0], sig_i};
            hist_r <= window_w[DENOISE_SAMPLES-2:0];
        end
    end

    // Level only moves once the whole window agrees
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            level_r <= 1'b0;
            rise_r  <= 1'b0;
            fall_r  <= 1'b0;
        end else begin
            rise_r <= all_high_w && !level_r;
            fall_r <= all_low_w && level_r;
            if (all_high_w) begin
                level_r <= 1'b1;
            end else if (all_low_w) begin
                level_r <= 1'b0;
            end
        end
    end

    assign level_o = level_r;
    assign rise_o  = rise_r;
    assign fall_o  = fall_r;

endmodule

//--- design/bus_activity_monitor.sv
`timescale 1ns/1ps

module bus_activity_monitor (
    input  logic                                  clk_logic_w,
    input  logic                                  arst_n_i,
    input  logic [a2_bus_pkg::NUM_BUS_CLOCKS-1:0] clk_level_i,
    input  logic [a2_bus_pkg::NUM_BUS_CLOCKS-1:0] clk_rise_i,
    input  logic [a2_bus_pkg::NUM_BUS_CLOCKS-1:0] clk_fall_i,
    output logic                                  phi0_o,
    output logic                                  cycle_end_o,
    output logic                                  clk_2m_edge_o,
    output logic                                  clk_14m_edge_o,
    output logic                                  sleep_o
);

    import a2_bus_pkg::*;

    logic                  phi1_edge_w;
    logic [IDLE_CNT_W-1:0] idle_cnt_r;
    logic                  idle_full_w;
    logic                  sleep_r;

    // Phi0 is the complement of Phi1 on the Apple bus
    assign phi0_o = ~clk_level_i[BUS_CLK_PHI1];

    // Bus cycle ends on the Phi1 rise
    assign cycle_end_o = clk_rise_i[BUS_CLK_PHI1];

    // Both edges of Phi1 give the 2 MHz strobe
    assign phi1_edge_w   = clk_rise_i[BUS_CLK_PHI1] | clk_fall_i[BUS_CLK_PHI1];
    assign clk_2m_edge_o = phi1_edge_w;

    // Both edges of 7M give the 14 MHz strobe
    assign clk_14m_edge_o = clk_rise_i[BUS_CLK_7M] | clk_fall_i[BUS_CLK_7M];

    assign idle_full_w = (idle_cnt_r == IDLE_CNT_W'(SLEEP_TIMEOUT_CYCLES));

    // Idle counter saturates, a Phi1 edge restarts it
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idle_cnt_r <= '0;
        end else if (phi1_edge_w) begin
            idle_cnt_r <= '0;
        end else if (!idle_full_w) begin
            idle_cnt_r <= idle_cnt_r + 1'b1;
        end
    end

    // Host CPU stopped, e.g. during reset or power down
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sleep_r <= 1'b0;
        end else if (phi1_edge_w) begin
            sleep_r <= 1'b0;
        end else if (idle_full_w) begin
            sleep_r <= 1'b1;
        end
    end

    assign sleep_o = sleep_r;

endmodule

//--- audio/speaker_toggle.sv
`timescale 1ns/1ps

module speaker_toggle (
    input  logic                  clk_logic_w,
    input  logic                  arst_n_i,
    input  a2_bus_pkg::bus_addr_t addr_i,
    input  logic                  cycle_end_i,
    output logic                  speaker_o
);

    import a2_bus_pkg::*;

    logic hit_w;
    logic speaker_r;

    // Address is stable at the end of the bus cycle
    assign hit_w = cycle_end_i && (addr_i == SPEAKER_ADDR);

    // Any access flips the cone, no data involved
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            speaker_r <= 1'b0;
        end else if (hit_w) begin
            speaker_r <= ~speaker_r;
        end
    end

    assign speaker_o = speaker_r;

endmodule

//--- design/card_output_merge.sv
`timescale 1ns/1ps

module card_output_merge (
    input  logic                                  clk_logic_w,
    input  logic                                  arst_n_i,
    input  a2_bus_pkg::bus_data_t                 bus_data_i,
    input  logic [a2_audio_pkg::NUM_CARDS-1:0]    card_rd_en_i,
    input  a2_bus_pkg::bus_data_t                 card_data_i [a2_audio_pkg::NUM_CARDS],
    input  logic [a2_audio_pkg::NUM_CARDS-1:0]    card_irq_n_i,
    output logic                                  data_out_en_o,
    output a2_bus_pkg::bus_data_t                 data_out_o,
    output logic                                  irq_n_o
);

    import a2_bus_pkg::*;
    import a2_audio_pkg::*;

    bus_data_t sel_data_w;
    bus_data_t data_r;
    logic      data_en_r;
    logic      irq_n_r;

    // Lowest card index wins, bus data passes through when nobody reads
    always_comb begin
        sel_data_w = bus_data_i;
        for (int i = NUM_CARDS - 1; i >= 0; i--) begin
            if (card_rd_en_i[i]) begin
                sel_data_w = card_data_i[i];
            end
        end
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_en_r <= 1'b0;
            data_r    <= '0;
            irq_n_r   <= 1'b1;
        end else begin
            data_en_r <= |card_rd_en_i;
            data_r    <= sel_data_w;
            // IRQ is open drain on the bus, any card pulls it low
            irq_n_r   <= &card_irq_n_i;
        end
    end

    assign data_out_en_o = data_en_r;
    assign data_out_o    = data_r;
    assign irq_n_o       = irq_n_r;

endmodule

//--- audio/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
    input  logic                      clk_logic_w,
    input  logic                      arst_n_i,
    input  a2_audio_pkg::card_audio_t card_audio_l_i [a2_audio_pkg::NUM_CARDS],
    input  a2_audio_pkg::card_audio_t card_audio_r_i [a2_audio_pkg::NUM_CARDS],
    input  logic                      speaker_i,
    output a2_audio_pkg::mix_sample_t audio_l_o,
    output a2_audio_pkg::mix_sample_t audio_r_o
);

    import a2_audio_pkg::*;

    mix_sample_t mix_l_w;
    mix_sample_t mix_r_w;
    mix_sample_t audio_l_r;
    mix_sample_t audio_r_r;

    // One channel, cards in 13 bits plus the speaker on the top part bit
    function automatic mix_sample_t mix_channel(
        input card_audio_t samples [NUM_CARDS],
        input logic        spk
    );
        logic [MIX_PART_W-1:0] part;
        logic [MIX_W-1:0]      acc;
        part = MIX_PART_W'(spk) << SPEAKER_SHIFT;
        acc  = MIX_W'(part);
        for (int i = 0; i < NUM_CARDS; i++) begin
            part = {samples[i], {CARD_AUDIO_SHIFT{1'b0}}};
            acc  = acc + MIX_W'(part);
        end
        // Three cards and the speaker stay below the sign bit
        return $signed(acc);
    endfunction

    assign mix_l_w = mix_channel(card_audio_l_i, speaker_i);
    assign mix_r_w = mix_channel(card_audio_r_i, speaker_i);

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            audio_l_r <= '0;
            audio_r_r <= '0;
        end else begin
            audio_l_r <= mix_l_w;
            audio_r_r <= mix_r_w;
        end
    end

    assign audio_l_o = audio_l_r;
    assign audio_r_o = audio_r_r;

endmodule

//--- design/a2_bus_core.sv
`timescale 1ns/1ps

module a2_bus_core (
    input  logic                                  clk_logic_w,
    input  logic                                  arst_n_i,
    input  logic [a2_bus_pkg::NUM_BUS_CLOCKS-1:0] bus_clk_i,
    input  a2_bus_pkg::bus_addr_t                 addr_i,
    input  a2_bus_pkg::bus_data_t                 bus_data_i,
    input  logic [a2_audio_pkg::NUM_CARDS-1:0]    card_rd_en_i,
    input  a2_bus_pkg::bus_data_t                 card_data_i [a2_audio_pkg::NUM_CARDS],
    input  logic [a2_audio_pkg::NUM_CARDS-1:0]    card_irq_n_i,
    input  a2_audio_pkg::card_audio_t             card_audio_l_i [a2_audio_pkg::NUM_CARDS],
    input  a2_audio_pkg::card_audio_t             card_audio_r_i [a2_audio_pkg::NUM_CARDS],
    output logic                                  phi0_o,
    output logic                                  clk_2m_edge_o,
    output logic                                  clk_14m_edge_o,
    output logic                                  sleep_o,
    output logic                                  data_out_en_o,
    output a2_bus_pkg::bus_data_t                 data_out_o,
    output logic                                  irq_n_o,
    output logic                                  speaker_o,
    output a2_audio_pkg::mix_sample_t             audio_l_o,
    output a2_audio_pkg::mix_sample_t             audio_r_o
);

    import a2_bus_pkg::*;

    logic [NUM_BUS_CLOCKS-1:0] clk_level_w;
    logic [NUM_BUS_CLOCKS-1:0] clk_rise_w;
    logic [NUM_BUS_CLOCKS-1:0] clk_fall_w;
    logic                      cycle_end_w;
    logic                      speaker_w;

    // Phi1 and 7M from the pins into the logic domain
    for (genvar k = 0; k < NUM_BUS_CLOCKS; k++) begin : g_denoise
        signal_denoise u_signal_denoise (
            .clk_logic_w (clk_logic_w),
            .arst_n_i    (arst_n_i),
            .sig_i       (bus_clk_i[k]),
            .level_o     (clk_level_w[k]),
            .rise_o      (clk_rise_w[k]),
            .fall_o      (clk_fall_w[k])
        );
    end

    bus_activity_monitor u_bus_activity_monitor (
        .clk_logic_w    (clk_logic_w),
        .arst_n_i       (arst_n_i),
        .clk_level_i    (clk_level_w),
        .clk_rise_i     (clk_rise_w),
        .clk_fall_i     (clk_fall_w),
        .phi0_o         (phi0_o),
        .cycle_end_o    (cycle_end_w),
        .clk_2m_edge_o  (clk_2m_edge_o),
        .clk_14m_edge_o (clk_14m_edge_o),
        .sleep_o        (sleep_o)
    );

    speaker_toggle u_speaker_toggle (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (arst_n_i),
        .addr_i      (addr_i),
        .cycle_end_i (cycle_end_w),
        .speaker_o   (speaker_w)
    );

    assign speaker_o = speaker_w;

    card_output_merge u_card_output_merge (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (arst_n_i),
        .bus_data_i    (bus_data_i),
        .card_rd_en_i  (card_rd_en_i),
        .card_data_i   (card_data_i),
        .card_irq_n_i  (card_irq_n_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer u_audio_mixer (
        .clk_logic_w    (clk_logic_w),
        .arst_n_i       (arst_n_i),
        .card_audio_l_i (card_audio_l_i),
        .card_audio_r_i (card_audio_r_i),
        .speaker_i      (speaker_w),
        .audio_l_o      (audio_l_o),
        .audio_r_o      (audio_r_o)
    );

endmodule

//--- bench/a2_bus_core_checker.sv
`timescale 1ns/1ps

module a2_bus_core_checker (
    input logic                                  clk_logic_w,
    input logic                                  arst_n_i,
    input logic [a2_bus_pkg::NUM_BUS_CLOCKS-1:0] bus_clk_i,
    input logic [a2_bus_pkg::NUM_BUS_CLOCKS-1:0] clk_level_i,
    input logic                                  phi0_i,
    input logic                                  clk_2m_edge_i,
    input logic                                  clk_14m_edge_i,
    input logic                                  cycle_end_i,
    input a2_bus_pkg::bus_addr_t                 addr_i,
    input logic                                  speaker_i,
    input logic                                  sleep_i
);

    import a2_bus_pkg::*;

    int   fail_cnt = 0;
    logic phi1_pin_w;
    logic m7_pin_w;

    assign phi1_pin_w = bus_clk_i[BUS_CLK_PHI1];
    assign m7_pin_w   = bus_clk_i[BUS_CLK_7M];

    // Edge strobe only after three agreeing pin samples behind the synchronizer
    a_2m_edge_filtered: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        clk_2m_edge_i |-> ($past(phi1_pin_w, 3) == $past(phi1_pin_w, 4)) &&
                          ($past(phi1_pin_w, 4) == $past(phi1_pin_w, 5)) &&
                          ($past(phi1_pin_w, 3) != phi0_i))
    else begin
        fail_cnt++;
        $error("2M edge strobe without a settled Phi1 pin level");
    end

    a_14m_edge_filtered: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        clk_14m_edge_i |-> ($past(m7_pin_w, 3) == $past(m7_pin_w, 4)) &&
                           ($past(m7_pin_w, 4) == $past(m7_pin_w, 5)) &&
                           ($past(m7_pin_w, 3) == clk_level_i[BUS_CLK_7M]))
    else begin
        fail_cnt++;
        $error("14M edge strobe without a settled 7M pin level");
    end

    // Speaker access flips the bit on the next cycle
    a_speaker_flip: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        (cycle_end_i && addr_i == SPEAKER_ADDR) |=> (speaker_i != $past(speaker_i)))
    else begin
        fail_cnt++;
        $error("speaker bit did not change after a speaker access");
    end

    a_sleep_wake: assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        clk_2m_edge_i |=> !sleep_i)
    else begin
        fail_cnt++;
        $error("sleep flag still high after a Phi1 edge");
    end

endmodule

bind a2_bus_core a2_bus_core_checker u_a2_bus_core_checker (
    .clk_logic_w    (clk_logic_w),
    .arst_n_i       (arst_n_i),
    .bus_clk_i      (bus_clk_i),
    .clk_level_i    (clk_level_w),
    .phi0_i         (phi0_o),
    .clk_2m_edge_i  (clk_2m_edge_o),
    .clk_14m_edge_i (clk_14m_edge_o),
    .cycle_end_i    (cycle_end_w),
    .addr_i         (addr_i),
    .speaker_i      (speaker_o),
    .sleep_i        (sleep_o)
);

//--- bench/a2_bus_core_tb.sv
`timescale 1ns/1ps

module a2_bus_core_tb;

    import a2_bus_pkg::*;
    import a2_audio_pkg::*;

    // Tests take about 4000 cycles
    localparam int TEST_CYCLES    = 4000;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;
    localparam int PHI1_HALF      = 28;
    localparam int M7_HALF        = 4;
    localparam int FILTER_DELAY   = SYNC_STAGES + DENOISE_SAMPLES;

    logic                      clk_logic_w;
    logic                      arst_n_i;
    logic [NUM_BUS_CLOCKS-1:0] bus_clk_i;
    bus_addr_t                 addr_i;
    bus_data_t                 bus_data_i;
    logic [NUM_CARDS-1:0]      card_rd_en_i;
    bus_data_t                 card_data_i [NUM_CARDS];
    logic [NUM_CARDS-1:0]      card_irq_n_i;
    card_audio_t               card_audio_l_i [NUM_CARDS];
    card_audio_t               card_audio_r_i [NUM_CARDS];
    logic                      phi0_o;
    logic                      clk_2m_edge_o;
    logic                      clk_14m_edge_o;
    logic                      sleep_o;
    logic                      data_out_en_o;
    bus_data_t                 data_out_o;
    logic                      irq_n_o;
    logic                      speaker_o;
    mix_sample_t               audio_l_o;
    mix_sample_t               audio_r_o;

    int        seed = 32'h6868_0e8b;
    int        errors = 0;
    int        assert_fails = 0;
    int        cycle_cnt = 0;
    int        cnt_2m = 0;
    int        cnt_14m = 0;
    int        cnt_spk = 0;
    logic      spk_prev = 1'b0;
    // Bus clock generator state
    logic      phi1_q = 1'b0;
    logic      m7_q = 1'b0;
    int        phi1_div = 0;
    int        m7_div = 0;
    int        phi1_edges = 0;
    int        m7_edges = 0;
    int        phi1_age = 100;
    bus_addr_t addr_next = '0;

    a2_bus_core u_a2_bus_core (.*);

    initial begin
        clk_logic_w = 1'b0;
        forever #2 clk_logic_w = ~clk_logic_w;
    end

    always @(posedge clk_logic_w) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    // Strobe and toggle counters, sampled away from the driving edge
    always @(negedge clk_logic_w) begin
        if (arst_n_i) begin
            cnt_2m  <= cnt_2m + int'(clk_2m_edge_o);
            cnt_14m <= cnt_14m + int'(clk_14m_edge_o);
            cnt_spk <= cnt_spk + int'(speaker_o != spk_prev);
            spk_prev <= speaker_o;
        end
    end

    task automatic check_eq(input string what, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // One logic cycle of Phi1 and 7M, then phi0_o check once the filter settled
    task automatic step_bus(input int n, input bit phi1_run, input bit m7_run);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_logic_w);
            addr_i <= addr_next;
            phi1_age++;
            if (phi1_run) begin
                phi1_div++;
                if (phi1_div == PHI1_HALF) begin
                    phi1_div = 0;
                    phi1_q = ~phi1_q;
                    phi1_edges++;
                    phi1_age = 0;
                end
            end
            if (m7_run) begin
                m7_div++;
                if (m7_div == M7_HALF) begin
                    m7_div = 0;
                    m7_q = ~m7_q;
                    m7_edges++;
                end
            end
            bus_clk_i[BUS_CLK_PHI1] <= phi1_q;
            bus_clk_i[BUS_CLK_7M]   <= m7_q;
            @(negedge clk_logic_w);
            if (phi1_age >= FILTER_DELAY) begin
                check_eq("phi0_o", int'(phi0_o), phi1_q ? 0 : 1);
            end
        end
    endtask

    task automatic glitch_phi1();
        @(posedge clk_logic_w);
        bus_clk_i[BUS_CLK_PHI1] <= ~phi1_q;
        repeat (2) @(posedge clk_logic_w);
        bus_clk_i[BUS_CLK_PHI1] <= phi1_q;
        phi1_age = 0;
    endtask

    // Next step_bus call toggles Phi1
    task automatic align_phi1();
        while (phi1_div != PHI1_HALF - 1) begin
            step_bus(1, 1'b1, 1'b1);
        end
    endtask

    task automatic recover_clocks();
        int e2m;
        int e14m;
        int p_edges;
        int m_edges;
        step_bus(8, 1'b0, 1'b0);
        e2m     = cnt_2m;
        e14m    = cnt_14m;
        p_edges = phi1_edges;
        m_edges = m7_edges;
        step_bus(8 * 2 * PHI1_HALF, 1'b1, 1'b1);
        step_bus(8, 1'b0, 1'b0);
        check_eq("2M edge count", cnt_2m - e2m, phi1_edges - p_edges);
        check_eq("14M edge count", cnt_14m - e14m, m7_edges - m_edges);
        e2m = cnt_2m;
        glitch_phi1();
        step_bus(8, 1'b0, 1'b0);
        check_eq("2M edges from a Phi1 glitch", cnt_2m - e2m, 0);
    endtask

    task automatic enter_and_leave_sleep();
        int waited;
        waited = 0;
        while (!sleep_o && waited < SLEEP_TIMEOUT_CYCLES + 8) begin
            step_bus(1, 1'b0, 1'b1);
            waited++;
        end
        assert (sleep_o) else begin
            errors++;
            $display("sleep_o stayed low %0d cycles after Phi1 stopped", waited);
        end
        phi1_div = PHI1_HALF - 1;
        waited = 0;
        while (sleep_o && waited < 8) begin
            step_bus(1, 1'b1, 1'b1);
            waited++;
        end
        assert (!sleep_o) else begin
            errors++;
            $display("sleep_o stayed high after Phi1 restarted");
        end
    endtask

    task automatic click_speaker();
        int start;
        align_phi1();
        addr_next = SPEAKER_ADDR;
        start = cnt_spk;
        step_bus(8 * PHI1_HALF, 1'b1, 1'b1);
        check_eq("speaker toggles on SPEAKER_ADDR", cnt_spk - start, 4);
        addr_next = 16'h0300;
        start = cnt_spk;
        step_bus(8 * PHI1_HALF, 1'b1, 1'b1);
        check_eq("speaker toggles on other address", cnt_spk - start, 0);
    endtask

    task automatic merge_card_outputs();
        logic [31:0] rnd;
        bus_data_t   exp_data;
        logic        found;
        for (int n = 0; n < 50; n++) begin
            @(posedge clk_logic_w);
            rnd = $random(seed);
            card_rd_en_i <= rnd[NUM_CARDS-1:0];
            card_irq_n_i <= rnd[8 +: NUM_CARDS];
            bus_data_i   <= rnd[31:24];
            for (int c = 0; c < NUM_CARDS; c++) begin
                rnd = $random(seed);
                card_data_i[c] <= rnd[7:0];
            end
            @(posedge clk_logic_w);
            @(negedge clk_logic_w);
            // Lowest enabled card wins, else the bus byte
            found    = 1'b0;
            exp_data = bus_data_i;
            for (int c = 0; c < NUM_CARDS; c++) begin
                if (card_rd_en_i[c] && !found) begin
                    exp_data = card_data_i[c];
                    found    = 1'b1;
                end
            end
            check_eq("data_out_en_o", int'(data_out_en_o), int'(found));
            check_eq("data_out_o", int'(data_out_o), int'(exp_data));
            check_eq("irq_n_o", int'(irq_n_o), int'(card_irq_n_i == '1));
        end
    endtask

    // Runs bus cycles on the speaker address until the bit matches
    task automatic set_speaker(input logic target);
        int waited;
        waited = 0;
        addr_next = SPEAKER_ADDR;
        while (speaker_o != target && waited < 4 * PHI1_HALF) begin
            step_bus(1, 1'b1, 1'b1);
            waited++;
        end
        addr_next = '0;
        assert (speaker_o == target) else begin
            errors++;
            $display("speaker_o never reached %0b through speaker accesses", target);
        end
    endtask

    task automatic mix_card_audio();
        logic [31:0] rnd;
        logic        spk;
        int          exp_l;
        int          exp_r;
        for (int n = 0; n < 50; n++) begin
            rnd = $random(seed);
            spk = rnd[0];
            set_speaker(spk);
            @(posedge clk_logic_w);
            addr_i <= addr_next;
            exp_l = int'(spk) << SPEAKER_SHIFT;
            exp_r = exp_l;
            for (int c = 0; c < NUM_CARDS; c++) begin
                rnd = $random(seed);
                card_audio_l_i[c] <= rnd[CARD_AUDIO_W-1:0];
                card_audio_r_i[c] <= rnd[16 +: CARD_AUDIO_W];
                exp_l += int'(rnd[CARD_AUDIO_W-1:0]) << CARD_AUDIO_SHIFT;
                exp_r += int'(rnd[16 +: CARD_AUDIO_W]) << CARD_AUDIO_SHIFT;
            end
            @(posedge clk_logic_w);
            @(negedge clk_logic_w);
            check_eq("speaker_o", int'(speaker_o), int'(spk));
            check_eq("audio_l_o", int'(audio_l_o), exp_l);
            check_eq("audio_r_o", int'(audio_r_o), exp_r);
        end
    endtask

    initial begin
        arst_n_i     <= 1'b0;
        bus_clk_i    <= '0;
        addr_i       <= '0;
        bus_data_i   <= '0;
        card_rd_en_i <= '0;
        card_irq_n_i <= '1;
        for (int c = 0; c < NUM_CARDS; c++) begin
            card_data_i[c]    <= '0;
            card_audio_l_i[c] <= '0;
            card_audio_r_i[c] <= '0;
        end
        repeat (10) @(posedge clk_logic_w);
        arst_n_i <= 1'b1;
        recover_clocks();
        enter_and_leave_sleep();
        click_speaker();
        merge_card_outputs();
        mix_card_audio();
        assert_fails = u_a2_bus_core.u_a2_bus_core_checker.fail_cnt;
        $display("Errors: %0d in testbench checks, %0d in bound assertions",
                 errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- a2_bus_core.f
common/a2_bus_pkg.sv
common/a2_audio_pkg.sv
design/signal_denoise.sv
design/bus_activity_monitor.sv
audio/speaker_toggle.sv
design/card_output_merge.sv
audio/audio_mixer.sv
design/a2_bus_core.sv
bench/a2_bus_core_checker.sv
bench/a2_bus_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the a2_bus_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert \
        --top-module a2_bus_core_tb \
        -f a2_bus_core.f \
        --Mdir obj_dir -o a2_bus_core_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/a2_bus_core_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
